// File: Bender.yml
package:
  name: orange_tracker

sources:
  # Packages first, then the pipeline stages and the top level
  - rtl/vision_pkg.sv
  - rtl/steer_pkg.sv
  - rtl/orange_threshold.sv
  - rtl/raster_tracker.sv
  - rtl/orange_classifier.sv
  - rtl/orange_tracker_top.sv
  - target: simulation
    files:
      - dv/tb_clock_gen.sv
      - dv/orange_tracker_tb.sv

// File: dv/orange_trace.txt
# name col_first col_last row_first row_last bg_rgb fg_rgb count detected direction mid_reset
# Colours are 3 hex digits R G B; direction 0 none, 1 left, 2 right, 3 center
# Frame is 16 x 8, left region columns 0-3, centre 4-11, right 12-15, threshold 10
right_block        12 15 0 7 000 C60  32 1 2 0
center_block        4 11 2 5 000 C60  32 1 3 0
left_block          0  3 0 5 000 C60  24 1 1 0
left_heavy          0  5 0 7 000 D51  48 1 1 0
right_heavy        10 15 0 7 000 E72  48 1 2 0
at_threshold        6  7 3 7 000 C60  10 0 0 0
just_over           0 10 0 0 000 C60  11 1 3 0
dim_background      0  1 0 3 B93 F90   8 0 0 0
red_below           0 15 0 7 000 B60   0 0 0 0
green_below         0 15 0 7 000 C30   0 0 0 0
green_above         0 15 0 7 000 CA0   0 0 0 0
blue_above          0 15 0 7 000 C64   0 0 0 0
window_low_corner   0 15 0 7 000 C40 128 1 3 0
window_high_corner  0 15 0 7 000 F93 128 1 3 0
orange_background   0 15 1 7 C60 000  16 1 3 0
mid_reset_frame    12 14 1 6 000 C60  18 1 2 1
after_reset        12 15 0 7 000 C60  32 1 2 0

// File: dv/orange_tracker_tb.sv
`default_nettype none

module orange_tracker_tb;

    import vision_pkg::*;
    import steer_pkg::*;

    localparam int WIDTH   = 16;
    localparam int HEIGHT  = 8;
    localparam int TIMEOUT = 40; // Cycle limit of every wait loop

    logic          clk;
    logic          por_reset;   // From the clock module
    logic          mid_reset;   // Pulse for the mid-frame reset test
    logic          reset;
    rgb444_t       pixel;
    logic          active_area;
    frame_result_t result;
    logic          result_valid;

    logic [11:0]   frame_mem [0:WIDTH*HEIGHT-1]; // Painted frame, row major
    logic [31:0]   lcg_state;
    int            pass_count;
    int            fail_count;
    int            valid_count; // Strobes seen since the test started
    int            hold_errors; // Result changes without a strobe
    frame_result_t prev_result;
    logic          was_reset;

    tb_clock_gen #(
        .PERIOD       (100),
        .RESET_CYCLES (5)
    ) u_tb_clock_gen (
        .clk   (clk),
        .reset (por_reset)
    );

    assign reset = por_reset | mid_reset;

    orange_tracker_top #(
        .FRAME_WIDTH  (WIDTH),
        .FRAME_HEIGHT (HEIGHT),
        .LEFT_EDGE    (4),
        .RIGHT_EDGE   (12),
        .THRESHOLD    (10)
    ) u_orange_tracker_top (
        .clk          (clk),
        .reset        (reset),
        .pixel        (pixel),
        .active_area  (active_area),
        .result       (result),
        .result_valid (result_valid)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Blanking before a line, 1 to 6 cycles
    function automatic int next_gap();
        lcg_state = lcg_next(lcg_state);
        return 1 + int'(lcg_state[23:16] % 8'd6); // Upper bits mix better
    endfunction

    // Strobe count and result hold, sampled on the edge before the flops move
    always @(posedge clk) begin
        if (reset || was_reset) begin
            prev_result = result; // Reset clears result legally
        end else begin
            if (result_valid) begin
                valid_count++;
            end else if (result !== prev_result) begin
                hold_errors++;
            end
            prev_result = result;
        end
        was_reset = reset;
    end

    task automatic drive_cycle(input logic [11:0] px, input logic act);
        @(posedge clk);
        #10;
        pixel       = px;
        active_area = act;
    endtask

    task automatic paint_frame(input int c0, input int c1, input int r0, input int r1,
                               input logic [11:0] bg, input logic [11:0] fg);
        for (int r = 0; r < HEIGHT; r++) begin
            for (int c = 0; c < WIDTH; c++) begin
                frame_mem[r*WIDTH + c] = (c >= c0 && c <= c1 && r >= r0 && r <= r1) ? fg : bg;
            end
        end
    endtask

    task automatic drive_frame();
        int gap;
        for (int r = 0; r < HEIGHT; r++) begin
            gap = next_gap();
            repeat (gap) drive_cycle(12'h000, 1'b0); // Line blanking
            for (int c = 0; c < WIDTH; c++) begin
                drive_cycle(frame_mem[r*WIDTH + c], 1'b1);
            end
        end
        drive_cycle(12'h000, 1'b0); // Close the last line
    endtask

    // Three lines and part of a fourth, then reset
    task automatic interrupt_with_reset(input logic [11:0] fg);
        for (int i = 0; i < 3*WIDTH + 7; i++) begin
            drive_cycle(fg, 1'b1);
        end
        drive_cycle(12'h000, 1'b0);
        mid_reset = 1'b1;
        repeat (3) drive_cycle(12'h000, 1'b0);
        mid_reset = 1'b0;
    endtask

    task automatic wait_result(output logic seen);
        seen = 1'b0;
        for (int i = 0; i < TIMEOUT && !seen; i++) begin
            @(negedge clk); // Outputs settled here
            seen = result_valid;
        end
    endtask

    task automatic run_test(input string name, input int c0, input int c1, input int r0,
                            input int r1, input logic [11:0] bg, input logic [11:0] fg,
                            input int exp_count, input int exp_det, input int exp_dir,
                            input int mid_rst);
        logic seen;
        logic ok;
        int   hold_start;
        ok          = 1'b1;
        hold_start  = hold_errors;
        valid_count = 0;
        if (mid_rst != 0) begin
            interrupt_with_reset(fg); // Partial frame must leave no trace
        end
        paint_frame(c0, c1, r0, r1, bg, fg);
        drive_frame();
        wait_result(seen);
        if (!seen) begin
            $display("%s: no result_valid within %0d cycles after the frame", name, TIMEOUT);
            ok = 1'b0;
        end else begin
            if (int'(result.orange_count) != exp_count) begin
                $display("Error: %s count expected %0d actual %0d",
                         name, exp_count, result.orange_count);
                ok = 1'b0;
            end
            if (result.detected != exp_det[0]) begin
                $display("Error: %s detected expected %0d actual %0d",
                         name, exp_det, result.detected);
                ok = 1'b0;
            end
            if (int'(result.direction) != exp_dir) begin
                $display("Error: %s direction expected %0d actual %0d",
                         name, exp_dir, result.direction);
                ok = 1'b0;
            end
            @(negedge clk); // Monitor has counted the strobe by now
            if (valid_count != 1) begin
                $display("Error: %s result_valid pulses expected 1 actual %0d",
                         name, valid_count);
                ok = 1'b0;
            end
        end
        if (hold_errors != hold_start) begin
            $display("%s: result changed while result_valid was low", name);
            ok = 1'b0;
        end
        if (ok) begin
            pass_count++;
            $display("PASS %s", name);
        end else begin
            fail_count++;
            $display("FAIL %s", name);
        end
    endtask

    initial begin
        int          fd;
        int          code;
        int          fields;
        string       line;
        string       name;
        int          c0, c1, r0, r1;
        int          exp_count, exp_det, exp_dir, mid_rst;
        logic [11:0] bg, fg;
        lcg_state   = 32'hbc51;
        pass_count  = 0;
        fail_count  = 0;
        valid_count = 0;
        hold_errors = 0;
        was_reset   = 1'b1;
        mid_reset   = 1'b0;
        pixel       = '0;
        active_area = 1'b0;
        for (int i = 0; i < TIMEOUT && reset !== 1'b0; i++) begin
            @(negedge clk);
        end
        if (reset !== 1'b0) begin
            $display("Reset never released");
            fail_count++;
        end else begin
            fd = $fopen("dv/orange_trace.txt", "r");
            if (fd == 0) begin
                $display("Could not open the trace file dv/orange_trace.txt");
                fail_count++;
            end else begin
                code = $fgets(line, fd);
                while (code != 0) begin
                    if (line.len() > 1 && line[0] != "#") begin // Skip comments and blanks
                        fields = $sscanf(line, "%s %d %d %d %d %h %h %d %d %d %d", name,
                                         c0, c1, r0, r1, bg, fg,
                                         exp_count, exp_det, exp_dir, mid_rst);
                        if (fields == 11) begin
                            run_test(name, c0, c1, r0, r1, bg, fg,
                                     exp_count, exp_det, exp_dir, mid_rst);
                        end else begin
                            $display("Trace line could not be read: %s", line);
                            fail_count++;
                        end
                    end
                    code = $fgets(line, fd);
                end
                $fclose(fd);
            end
        end
        if (pass_count + fail_count == 0) begin
            $display("No tests were found in the trace");
            fail_count++;
        end
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 100, // Clock period in time units
    parameter int RESET_CYCLES = 5    // Rising edges that see reset high
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #10 reset = 1'b0; // Release just after an edge, like the other inputs
    end

endmodule

`default_nettype wire

// File: project.f
rtl/vision_pkg.sv
rtl/steer_pkg.sv
rtl/orange_threshold.sv
rtl/raster_tracker.sv
rtl/orange_classifier.sv
rtl/orange_tracker_top.sv
dv/tb_clock_gen.sv
dv/orange_tracker_tb.sv

// File: rtl/orange_classifier.sv
`default_nettype none

module orange_classifier #(
    parameter int LEFT_EDGE  = 70,  // First centre column
    parameter int RIGHT_EDGE = 290, // First right column
    parameter int THRESHOLD  = 768  // Count must be above this to detect
) (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire vision_pkg::pixel_stream_t stage_stream,
    input  wire vision_pkg::column_t       column,
    input  wire logic                      frame_end,
    output steer_pkg::frame_result_t       result,
    output logic                           result_valid
);

    import vision_pkg::*;
    import steer_pkg::*;

    logic [COUNT_W-1:0] left_count;   // Orange pixels left of LEFT_EDGE
    logic [COUNT_W-1:0] center_count; // Between the two edges
    logic [COUNT_W-1:0] right_count;  // At or beyond RIGHT_EDGE
    logic [COUNT_W-1:0] total_count;

    logic               in_left;
    logic               in_center;
    logic               hit_left;
    logic               hit_center;
    logic               hit_right;

    // Counts with the current stage pixel included
    logic [COUNT_W-1:0] left_next;
    logic [COUNT_W-1:0] center_next;
    logic [COUNT_W-1:0] right_next;
    logic [COUNT_W-1:0] total_next;

    logic               detected_next;
    direction_t         direction_next;

    // Region select, exactly one region per column
    assign in_left   = (int'(column) < LEFT_EDGE);
    assign in_center = !in_left && (int'(column) < RIGHT_EDGE);

    assign hit_left   = stage_stream.is_orange && in_left;
    assign hit_center = stage_stream.is_orange && in_center;
    assign hit_right  = stage_stream.is_orange && !in_left && !in_center;

    assign left_next   = left_count   + COUNT_W'(hit_left);
    assign center_next = center_count + COUNT_W'(hit_center);
    assign right_next  = right_count  + COUNT_W'(hit_right);
    assign total_next  = total_count  + COUNT_W'(stage_stream.is_orange);

    // Frame decision, first matching rule wins
    always_comb begin
        detected_next  = (total_next > THRESHOLD);
        direction_next = NONE;
        if (detected_next) begin
            if (right_next > left_next) begin
                direction_next = RIGHT;
            end else if ((center_next > right_next) && (center_next > left_next)) begin
                direction_next = CENTER;
            end else if (left_next > right_next) begin
                direction_next = LEFT;
            end
            // Ties between left and right stay NONE
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            left_count   <= '0;
            center_count <= '0;
            right_count  <= '0;
            total_count  <= '0;
            result       <= '0; // Direction NONE, not detected
            result_valid <= 1'b0;
        end else begin
            result_valid <= frame_end; // One-cycle strobe
            if (frame_end) begin
                result <= '{
                    orange_count: total_next,
                    detected:     detected_next,
                    direction:    direction_next
                };
                // Start the next frame from zero
                left_count   <= '0;
                center_count <= '0;
                right_count  <= '0;
                total_count  <= '0;
            end else begin
                left_count   <= left_next;
                center_count <= center_next;
                right_count  <= right_next;
                total_count  <= total_next;
            end
        end
    end

    // Frame end is the last pixel of a frame, so strobes are never adjacent
    a_valid_pulse: assert property (
        @(posedge clk) disable iff (reset)
        result_valid |=> !result_valid
    ) else $error("result_valid high two cycles in a row");

    // Regions partition the total at the point the frame closes
    a_region_sum: assert property (
        @(posedge clk) disable iff (reset)
        frame_end |-> ((COUNT_W + 2)'(left_count) + (COUNT_W + 2)'(center_count) +
                       (COUNT_W + 2)'(right_count) == (COUNT_W + 2)'(total_count))
    ) else $error("region counts do not sum to total %0d", total_count);

endmodule

`default_nettype wire

// File: rtl/orange_threshold.sv
`default_nettype none

module orange_threshold (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire vision_pkg::rgb444_t   pixel,
    input  wire logic                  active_area,
    output vision_pkg::pixel_stream_t  stage_stream
);

    import vision_pkg::*;

    rgb444_t pixel_q;   // Registered pixel value
    logic    active_q;  // Registered active level
    logic    orange_q;  // Registered orange mark
    logic    in_window; // Incoming pixel inside the colour window

    // Window test on the raw input with every bound inclusive
    assign in_window = (pixel.red   >= ORANGE_RED_MIN)   &&
                       (pixel.green >= ORANGE_GREEN_MIN) &&
                       (pixel.green <= ORANGE_GREEN_MAX) &&
                       (pixel.blue  <= ORANGE_BLUE_MAX);

    always_ff @(posedge clk) begin
        pixel_q <= pixel; // Payload only
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active_q <= 1'b0;
            orange_q <= 1'b0;
        end else begin
            active_q <= active_area;
            // Blanking pixels never count whatever their colour
            orange_q <= active_area && in_window;
        end
    end

    assign stage_stream = '{
        pixel:     pixel_q,
        active:    active_q,
        is_orange: orange_q
    };

endmodule

`default_nettype wire

// File: rtl/orange_tracker_top.sv
`default_nettype none

module orange_tracker_top #(
    parameter int FRAME_WIDTH  = 320,
    parameter int FRAME_HEIGHT = 240,
    parameter int LEFT_EDGE    = 70,  // Left region is columns 0 to 69
    parameter int RIGHT_EDGE   = 290, // Right region starts here
    parameter int THRESHOLD    = 768  // About one percent of the default frame
) (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire vision_pkg::rgb444_t  pixel,
    input  wire logic                 active_area,
    output steer_pkg::frame_result_t  result,
    output logic                      result_valid
);

    import vision_pkg::*;

    pixel_stream_t stage_stream; // Registered pixel with orange mark
    column_t       column;       // Column of the stage pixel
    logic          frame_end;    // Last active pixel of the frame

    orange_threshold u_orange_threshold (
        .clk          (clk),
        .reset        (reset),
        .pixel        (pixel),
        .active_area  (active_area),
        .stage_stream (stage_stream)
    );

    raster_tracker #(
        .FRAME_WIDTH  (FRAME_WIDTH),
        .FRAME_HEIGHT (FRAME_HEIGHT)
    ) u_raster_tracker (
        .clk          (clk),
        .reset        (reset),
        .stage_stream (stage_stream),
        .column       (column),
        .line_end     (),  // Only used inside the tracker
        .frame_end    (frame_end)
    );

    orange_classifier #(
        .LEFT_EDGE    (LEFT_EDGE),
        .RIGHT_EDGE   (RIGHT_EDGE),
        .THRESHOLD    (THRESHOLD)
    ) u_orange_classifier (
        .clk          (clk),
        .reset        (reset),
        .stage_stream (stage_stream),
        .column       (column),
        .frame_end    (frame_end),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

`default_nettype wire

// File: rtl/raster_tracker.sv
`default_nettype none

module raster_tracker #(
    parameter int FRAME_WIDTH  = 320, // Active pixels per line
    parameter int FRAME_HEIGHT = 240  // Lines per frame
) (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire vision_pkg::pixel_stream_t stage_stream,
    output vision_pkg::column_t            column,
    output logic                           line_end,
    output logic                           frame_end
);

    import vision_pkg::*;

    // Row counter only needs to reach FRAME_HEIGHT-1
    localparam int ROW_W = (FRAME_HEIGHT > 1) ? $clog2(FRAME_HEIGHT) : 1;

    column_t          col_count; // Column of the current stage pixel
    logic [ROW_W-1:0] row_count; // Line within the frame

    // Outputs follow the stage pixel with no extra delay
    assign column    = col_count;
    assign line_end  = stage_stream.active && (col_count == column_t'(FRAME_WIDTH - 1));
    assign frame_end = line_end && (row_count == ROW_W'(FRAME_HEIGHT - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            col_count <= '0;
            row_count <= '0;
        end else if (!stage_stream.active) begin
            // Blanking or a short line restarts at column 0
            col_count <= '0;
        end else if (line_end) begin
            col_count <= '0;
            if (frame_end) begin
                row_count <= '0; // Wrap for the next frame
            end else begin
                row_count <= row_count + 1'b1;
            end
        end else begin
            col_count <= col_count + 1'b1;
        end
    end

    // Column never runs past the end of the line
    a_column_bound: assert property (
        @(posedge clk) disable iff (reset)
        stage_stream.active |-> (int'(column) < FRAME_WIDTH)
    ) else $error("column %0d out of range", column);

    // Row counter stays inside the frame
    a_row_bound: assert property (
        @(posedge clk) disable iff (reset)
        int'(row_count) < FRAME_HEIGHT
    ) else $error("row %0d out of range", row_count);

endmodule

`default_nettype wire

// File: rtl/steer_pkg.sv
`default_nettype none

package steer_pkg;

    // Steering decision reported once per frame
    typedef enum logic [2:0] {
        NONE   = 3'd0, // Nothing found or no clear winner
        LEFT   = 3'd1,
        RIGHT  = 3'd2,
        CENTER = 3'd3
    } direction_t;

    // Per-frame result word, 22 bits
    typedef struct packed {
        logic [vision_pkg::COUNT_W-1:0] orange_count; // Orange pixels in the frame
        logic                           detected;     // Count above threshold
        direction_t                     direction;    // Only set when detected
    } frame_result_t;

endpackage

`default_nettype wire

// File: rtl/vision_pkg.sv
`default_nettype none

package vision_pkg;

    // One camera pixel, 4 bits per channel
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb444_t;

    // Stream word between pipeline stages
    typedef struct packed {
        rgb444_t pixel;     // Registered pixel value
        logic    active;    // High during visible pixels of a line
        logic    is_orange; // Active pixel inside the colour window
    } pixel_stream_t;

    // Orange colour window, every bound inclusive
    localparam logic [3:0] ORANGE_RED_MIN   = 4'd12; // Strong red
    localparam logic [3:0] ORANGE_GREEN_MIN = 4'd4;
    localparam logic [3:0] ORANGE_GREEN_MAX = 4'd9;  // Mid green, above this turns yellow
    localparam logic [3:0] ORANGE_BLUE_MAX  = 4'd3;  // Little blue

    // Width of all orange pixel counters
    localparam int COUNT_W = 18;

    // Column index, 10 bits covers lines up to 1024 pixels
    localparam int COLUMN_W = 10;
    typedef logic [COLUMN_W-1:0] column_t;

endpackage

`default_nettype wire
